/* run_sim.sh */
#!/bin/sh
# Build and run the video_upscaler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f video_upscaler.f \
	--top-module tb_video_upscaler \
	--Mdir obj_dir -o tb_video_upscaler
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/tb_video_upscaler > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi
exit 0

/* source/line_buffer_ring.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer_ring #(
	parameter int LINE_BUFFER_COUNT = 8,
	parameter int LINE_MAX = 1024
) (
	input  wire                                   i_clk,
	input  wire                                   i_wr_en,
	input  wire [$clog2(LINE_BUFFER_COUNT)-1:0]   i_wr_slot,
	input  wire video_pkg::dim_t                  i_wr_col,
	input  wire video_pkg::rgb_t                  i_wr_rgb,
	input  wire [$clog2(LINE_BUFFER_COUNT)-1:0]   i_rd_slot,
	input  wire video_pkg::dim_t                  i_rd_col,
	output video_pkg::rgb_t                       o_rd_rgb
);

	localparam int DEPTH = LINE_BUFFER_COUNT * LINE_MAX;
	localparam int ADDR_W = $clog2(DEPTH);

	// All lines in one array, slot-major
	video_pkg::rgb_t mem [DEPTH];

	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;

	assign wr_addr = ADDR_W'(int'(i_wr_slot) * LINE_MAX + int'(i_wr_col));
	assign rd_addr = ADDR_W'(int'(i_rd_slot) * LINE_MAX + int'(i_rd_col));

	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			mem[wr_addr] <= i_wr_rgb;
		end
	end

	// Registered read, data one cycle after address
	always_ff @(posedge i_clk) begin
		o_rd_rgb <= mem[rd_addr];
	end

	// Source lines wider than a line memory would spill into the next slot
	a_wr_col_range: assert property (@(posedge i_clk)
		i_wr_en |-> int'(i_wr_col) < LINE_MAX);

endmodule

`default_nettype wire

/* source/scale_step_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module scale_step_divider (
	input  wire                        i_clk,
	input  wire                        i_rst,
	input  wire                        i_req,
	input  wire scaler_pkg::div_req_t  i_op,
	output logic                       o_ack,
	output scaler_pkg::div_rsp_t       o_rsp
);

	localparam int DIM_W = $bits(video_pkg::dim_t);
	localparam int STEP_W = $bits(scaler_pkg::step_t);
	localparam int CNT_W = $clog2(STEP_W + 1);

	logic busy;
	logic load;
	logic [CNT_W-1:0] cnt;
	video_pkg::dim_t rem;
	video_pkg::dim_t divisor;
	scaler_pkg::step_t quo;
	logic [DIM_W:0] shifted;
	logic [DIM_W+1:0] diff;

	// New request only after the previous ack has dropped
	assign load = i_req && !busy && !o_ack;

	// Trial subtraction, top bit is the borrow
	assign shifted = {rem, quo[STEP_W-1]};
	assign diff = {1'b0, shifted} - {2'b00, divisor};

	assign o_rsp.quotient = quo;

	// Handshake and bit counter
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			busy <= 1'b0;
			o_ack <= 1'b0;
			cnt <= '0;
		end else if (busy) begin
			cnt <= cnt - 1'b1;
			if (cnt == CNT_W'(1)) begin
				busy <= 1'b0;
				o_ack <= 1'b1;
			end
		end else if (load) begin
			busy <= 1'b1;
			cnt <= CNT_W'(STEP_W);
		end else if (o_ack && !i_req) begin
			o_ack <= 1'b0;
		end
	end

	// Dividend bits shift out the top as quotient bits shift in
	always_ff @(posedge i_clk) begin
		if (load) begin
			rem <= '0;
			divisor <= i_op.divisor;
			quo <= {i_op.dividend, {scaler_pkg::STEP_FRAC{1'b0}}};
		end else if (busy) begin
			rem <= diff[DIM_W+1] ? shifted[DIM_W-1:0] : diff[DIM_W-1:0];
			quo <= {quo[STEP_W-2:0], !diff[DIM_W+1]};
		end
	end

	a_req_held: assert property (@(posedge i_clk) disable iff (i_rst)
		$fell(i_req) |-> o_ack);

endmodule

`default_nettype wire

/* source/scaler_pkg.sv */
`default_nettype none

package scaler_pkg;

	// Fraction bits of a scale step
	localparam int STEP_FRAC = 12;

	// Whole part as wide as a dimension
	localparam int STEP_WIDTH = $bits(video_pkg::dim_t) + STEP_FRAC;

	typedef logic [STEP_WIDTH-1:0] step_t;

	// Source dimension over output active dimension
	typedef struct packed {
		video_pkg::dim_t dividend;
		video_pkg::dim_t divisor;
	} div_req_t;

	typedef struct packed {
		step_t quotient;
	} div_rsp_t;

endpackage

`default_nettype wire

/* source/upscaler_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module upscaler_ctrl #(
	parameter int LINE_BUFFER_COUNT = 8
) (
	input  wire                                   i_clk,
	input  wire                                   i_rst,
	// Source geometry from the monitor
	input  wire                                   i_locked,
	input  wire video_pkg::dim_t                  i_width,
	input  wire video_pkg::dim_t                  i_height,
	input  wire video_pkg::dim_t                  i_src_line,
	input  wire                                   i_frame_start,
	output logic [$clog2(LINE_BUFFER_COUNT)-1:0]  o_wr_slot,
	// Step divider
	output logic                                  o_div_req,
	output scaler_pkg::div_req_t                  o_div_op,
	input  wire                                   i_div_ack,
	input  wire scaler_pkg::div_rsp_t             i_div_rsp,
	// Output timing
	output logic                                  o_start,
	input  wire                                   i_running,
	input  wire video_pkg::dim_t                  i_hpos,
	input  wire video_pkg::dim_t                  i_vpos,
	input  wire video_pkg::dim_t                  i_h_active,
	input  wire video_pkg::dim_t                  i_v_active,
	input  wire video_pkg::video_sync_t           i_sync,
	// Line buffer read
	output logic [$clog2(LINE_BUFFER_COUNT)-1:0]  o_rd_slot,
	output video_pkg::dim_t                       o_rd_col,
	input  wire video_pkg::rgb_t                  i_rd_rgb,
	// Output video
	output video_pkg::rgb_t                       o_rgb,
	output video_pkg::video_sync_t                o_sync,
	output logic                                  o_out_valid,
	output logic                                  o_locked
);

	localparam int SLOT_W = $clog2(LINE_BUFFER_COUNT);
	localparam int DIM_W = $bits(video_pkg::dim_t);
	// Output may start once half the ring holds the new frame
	localparam video_pkg::dim_t FILL_LINE = video_pkg::dim_t'(LINE_BUFFER_COUNT / 2 - 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_WAIT_LOCK,
		S_DIV_H,
		S_DIV_V,
		S_WAIT_FILL,
		S_RUN,
		S_DRAIN
	} state_t;

	state_t state;
	logic seen_start;
	logic hblank_q;
	logic line_end;
	logic [1:0] valid_d;
	video_pkg::dim_t wr_line;
	video_pkg::video_sync_t sync_d1;
	scaler_pkg::step_t h_step;
	scaler_pkg::step_t v_step;
	scaler_pkg::step_t h_acc;
	scaler_pkg::step_t v_acc;
	scaler_pkg::step_t h_acc_cur;
	scaler_pkg::step_t v_acc_cur;

	////////////////////////////////////////////////////////////
	// Control

	// Line being written is one past the last completed one
	assign wr_line = i_src_line + 1'b1;
	assign o_wr_slot = wr_line[SLOT_W-1:0];

	// Op held steady for the whole request
	assign o_div_op.dividend = (state == S_DIV_V) ? i_height : i_width;
	assign o_div_op.divisor = (state == S_DIV_V) ? i_v_active : i_h_active;

	assign o_start = state == S_RUN;
	assign o_locked = state inside {S_DIV_H, S_DIV_V, S_WAIT_FILL, S_RUN};

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= S_IDLE;
			o_div_req <= 1'b0;
			seen_start <= 1'b0;
		end else begin
			seen_start <= 1'b0;
			case (state)
				// Previous handshake must be fully closed
				S_IDLE: if (!i_div_ack) state <= S_WAIT_LOCK;
				S_WAIT_LOCK: if (i_locked) state <= S_DIV_H;
				S_DIV_H, S_DIV_V: begin
					if (!o_div_req && !i_div_ack) begin
						o_div_req <= 1'b1;
					end else if (o_div_req && i_div_ack) begin
						o_div_req <= 1'b0;
						state <= (state == S_DIV_H) ? S_DIV_V : S_WAIT_FILL;
					end
				end
				S_WAIT_FILL: begin
					seen_start <= seen_start || i_frame_start;
					if (!i_locked) begin
						state <= S_IDLE;
					end else if (seen_start && i_src_line == FILL_LINE) begin
						state <= S_RUN;
					end
				end
				S_RUN: if (!i_locked) state <= S_DRAIN;
				// Generator finishes its frame on its own
				S_DRAIN: if (!i_running) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_div_req && i_div_ack) begin
			if (state == S_DIV_H) begin
				h_step <= i_div_rsp.quotient;
			end else begin
				v_step <= i_div_rsp.quotient;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Source coordinates

	// Accumulators restart at the origin of each line and frame
	assign h_acc_cur = (i_hpos == '0) ? '0 : h_acc;
	assign v_acc_cur = (i_vpos == '0) ? '0 : v_acc;

	// First blank pixel of an active line
	assign line_end = i_sync.hblank && !hblank_q && !i_sync.vblank;

	always_ff @(posedge i_clk) begin
		h_acc <= h_acc_cur + h_step;
		if (line_end) begin
			v_acc <= v_acc_cur + v_step;
		end
		// Nearest neighbour, whole parts only
		o_rd_col <= h_acc_cur[scaler_pkg::STEP_FRAC +: DIM_W];
		o_rd_slot <= v_acc_cur[scaler_pkg::STEP_FRAC +: SLOT_W];
	end

	////////////////////////////////////////////////////////////
	// Output alignment

	// Two stages to match address register plus memory read
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			hblank_q <= 1'b1;
			sync_d1 <= video_pkg::SYNC_IDLE;
			o_sync <= video_pkg::SYNC_IDLE;
			valid_d <= 2'b00;
		end else begin
			hblank_q <= i_sync.hblank;
			sync_d1 <= i_sync;
			o_sync <= sync_d1;
			valid_d <= {valid_d[0], state == S_RUN && i_running};
		end
	end

	assign o_rgb = (o_sync.hblank || o_sync.vblank) ? '0 : i_rd_rgb;
	assign o_out_valid = valid_d[1] && state == S_RUN;

	// Valid pixels come only from addresses issued while locked
	a_valid_locked: assert property (@(posedge i_clk) disable iff (i_rst)
		o_out_valid |-> o_locked && $past(i_locked, 2));

endmodule

`default_nettype wire

/* source/vga_timing_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing_gen #(
	parameter int OUT_H_ACTIVE = 640,
	parameter int OUT_H_FRONT  = 16,
	parameter int OUT_H_SYNC   = 96,
	parameter int OUT_H_BACK   = 48,
	parameter int OUT_V_ACTIVE = 480,
	parameter int OUT_V_FRONT  = 10,
	parameter int OUT_V_SYNC   = 2,
	parameter int OUT_V_BACK   = 33
) (
	input  wire                      i_clk,
	input  wire                      i_rst,
	input  wire                      i_start,
	output logic                     o_running,
	output video_pkg::dim_t          o_hpos,
	output video_pkg::dim_t          o_vpos,
	output video_pkg::dim_t          o_h_active,
	output video_pkg::dim_t          o_v_active,
	output video_pkg::video_sync_t   o_sync
);

	localparam int H_TOTAL = OUT_H_ACTIVE + OUT_H_FRONT + OUT_H_SYNC + OUT_H_BACK;
	localparam int V_TOTAL = OUT_V_ACTIVE + OUT_V_FRONT + OUT_V_SYNC + OUT_V_BACK;

	// Region edges; active comes first so the counters are the pixel coordinates
	localparam video_pkg::dim_t H_LAST       = video_pkg::dim_t'(H_TOTAL - 1);
	localparam video_pkg::dim_t V_LAST       = video_pkg::dim_t'(V_TOTAL - 1);
	localparam video_pkg::dim_t H_SYNC_START = video_pkg::dim_t'(OUT_H_ACTIVE + OUT_H_FRONT);
	localparam video_pkg::dim_t H_SYNC_END   = video_pkg::dim_t'(H_SYNC_START + OUT_H_SYNC);
	localparam video_pkg::dim_t V_SYNC_START = video_pkg::dim_t'(OUT_V_ACTIVE + OUT_V_FRONT);
	localparam video_pkg::dim_t V_SYNC_END   = video_pkg::dim_t'(V_SYNC_START + OUT_V_SYNC);

	assign o_h_active = video_pkg::dim_t'(OUT_H_ACTIVE);
	assign o_v_active = video_pkg::dim_t'(OUT_V_ACTIVE);

	// Counters rest at the frame origin while stopped
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_running <= 1'b0;
			o_hpos <= '0;
			o_vpos <= '0;
		end else if (!o_running) begin
			o_running <= i_start;
		end else if (o_hpos == H_LAST) begin
			o_hpos <= '0;
			if (o_vpos == V_LAST) begin
				o_vpos <= '0;
				// Frame boundary, keep going only on request
				o_running <= i_start;
			end else begin
				o_vpos <= o_vpos + 1'b1;
			end
		end else begin
			o_hpos <= o_hpos + 1'b1;
		end
	end

	// Negative sync pulses
	always_comb begin
		if (!o_running) begin
			o_sync = video_pkg::SYNC_IDLE;
		end else begin
			o_sync.hblank = o_hpos >= o_h_active;
			o_sync.vblank = o_vpos >= o_v_active;
			o_sync.hsync = !(o_hpos >= H_SYNC_START && o_hpos < H_SYNC_END);
			o_sync.vsync = !(o_vpos >= V_SYNC_START && o_vpos < V_SYNC_END);
		end
	end

	a_hpos_range: assert property (@(posedge i_clk) disable iff (i_rst)
		int'(o_hpos) < H_TOTAL);

endmodule

`default_nettype wire

/* source/video_pkg.sv */
`default_nettype none

package video_pkg;

	// Bits per colour component
	localparam int COMPONENT_DEPTH = 4;

	// Pixel and line counts, coordinates
	localparam int DIM_WIDTH = 12;

	typedef logic [COMPONENT_DEPTH-1:0] color_t;
	typedef logic [DIM_WIDTH-1:0] dim_t;

	typedef struct packed {
		color_t red;
		color_t green;
		color_t blue;
	} rgb_t;

	// Syncs are active low, blanks active high
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic hblank;
		logic vblank;
	} video_sync_t;

	// Raster at rest: no sync pulse, fully blanked
	localparam video_sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, hblank: 1'b1, vblank: 1'b1};

	typedef struct packed {
		rgb_t rgb;
		video_sync_t sync;
	} src_pixel_t;

endpackage

`default_nettype wire

/* source/video_timing_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timing_monitor (
	input  wire                      i_clk,
	input  wire                      i_rst,
	input  wire video_pkg::src_pixel_t i_src,
	input  wire                      i_src_pix_en,
	output logic                     o_locked,
	output video_pkg::dim_t          o_width,
	output video_pkg::dim_t          o_height,
	output video_pkg::dim_t          o_col,
	output logic                     o_wr_en,
	output video_pkg::dim_t          o_src_line,
	output logic                     o_frame_start
);

	logic active;
	logic active_q;
	logic vblank_q;
	logic line_end;
	logic frame_end;
	video_pkg::dim_t col;
	video_pkg::dim_t line_width;
	video_pkg::dim_t width_now;
	video_pkg::dim_t height_now;

	assign active = !i_src.sync.hblank && !i_src.sync.vblank;

	// Edges, only on strobed pixels
	assign line_end = i_src_pix_en && active_q && !active;
	assign frame_end = i_src_pix_en && i_src.sync.vblank && !vblank_q;

	// Write port of the ring
	assign o_wr_en = i_src_pix_en && active;
	assign o_col = col;

	// Geometry of the frame that just closed
	// A line may end on the same pixel that opens vblank
	assign width_now = line_end ? col : line_width;
	assign height_now = line_end ? o_src_line + 2'd2 : o_src_line + 1'b1;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			active_q <= 1'b0;
			vblank_q <= 1'b1;
			col <= '0;
			line_width <= '0;
			o_src_line <= '1;
			o_width <= '0;
			o_height <= '0;
			o_locked <= 1'b0;
			o_frame_start <= 1'b0;
		end else begin
			o_frame_start <= i_src_pix_en && !i_src.sync.vblank && vblank_q;
			if (i_src_pix_en) begin
				active_q <= active;
				vblank_q <= i_src.sync.vblank;
				col <= active ? col + 1'b1 : '0;
			end
			if (line_end) begin
				line_width <= col;
				o_src_line <= o_src_line + 1'b1;
			end
			if (frame_end) begin
				// Two equal frames in a row give lock, any change drops it
				o_locked <= width_now == o_width && height_now == o_height &&
					width_now != '0 && height_now != '0;
				o_width <= width_now;
				o_height <= height_now;
				// No line completed yet in the next frame
				o_src_line <= '1;
			end
		end
	end

endmodule

`default_nettype wire

/* source/video_upscaler_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_upscaler_top #(
	parameter int LINE_BUFFER_COUNT = 8,
	parameter int LINE_MAX     = 1024,
	parameter int OUT_H_ACTIVE = 640,
	parameter int OUT_H_FRONT  = 16,
	parameter int OUT_H_SYNC   = 96,
	parameter int OUT_H_BACK   = 48,
	parameter int OUT_V_ACTIVE = 480,
	parameter int OUT_V_FRONT  = 10,
	parameter int OUT_V_SYNC   = 2,
	parameter int OUT_V_BACK   = 33
) (
	input  wire                        i_clk,
	input  wire                        i_rst,
	input  wire video_pkg::src_pixel_t i_src,
	input  wire                        i_src_pix_en,
	output video_pkg::rgb_t            o_rgb,
	output video_pkg::video_sync_t     o_sync,
	output logic                       o_out_valid,
	output logic                       o_locked,
	output video_pkg::dim_t            o_src_width,
	output video_pkg::dim_t            o_src_height
);

	localparam int SLOT_W = $clog2(LINE_BUFFER_COUNT);

	// Source side
	logic mon_locked;
	logic mon_wr_en;
	logic mon_frame_start;
	video_pkg::dim_t mon_col;
	video_pkg::dim_t mon_src_line;
	logic [SLOT_W-1:0] wr_slot;

	// Divider handshake
	logic div_req;
	logic div_ack;
	scaler_pkg::div_req_t div_op;
	scaler_pkg::div_rsp_t div_rsp;

	// Output timing and line reads
	logic gen_start;
	logic gen_running;
	video_pkg::dim_t gen_hpos;
	video_pkg::dim_t gen_vpos;
	video_pkg::dim_t gen_h_active;
	video_pkg::dim_t gen_v_active;
	video_pkg::video_sync_t gen_sync;
	logic [SLOT_W-1:0] rd_slot;
	video_pkg::dim_t rd_col;
	video_pkg::rgb_t rd_rgb;

	////////////////////////////////////////////////////////////
	// Datapath blocks

	video_timing_monitor monitor (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_src(i_src),
		.i_src_pix_en(i_src_pix_en),
		.o_locked(mon_locked),
		.o_width(o_src_width),
		.o_height(o_src_height),
		.o_col(mon_col),
		.o_wr_en(mon_wr_en),
		.o_src_line(mon_src_line),
		.o_frame_start(mon_frame_start)
	);

	line_buffer_ring #(
		.LINE_BUFFER_COUNT(LINE_BUFFER_COUNT),
		.LINE_MAX(LINE_MAX)
	) ring (
		.i_clk(i_clk),
		.i_wr_en(mon_wr_en),
		.i_wr_slot(wr_slot),
		.i_wr_col(mon_col),
		.i_wr_rgb(i_src.rgb),
		.i_rd_slot(rd_slot),
		.i_rd_col(rd_col),
		.o_rd_rgb(rd_rgb)
	);

	scale_step_divider divider (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_req(div_req),
		.i_op(div_op),
		.o_ack(div_ack),
		.o_rsp(div_rsp)
	);

	vga_timing_gen #(
		.OUT_H_ACTIVE(OUT_H_ACTIVE),
		.OUT_H_FRONT(OUT_H_FRONT),
		.OUT_H_SYNC(OUT_H_SYNC),
		.OUT_H_BACK(OUT_H_BACK),
		.OUT_V_ACTIVE(OUT_V_ACTIVE),
		.OUT_V_FRONT(OUT_V_FRONT),
		.OUT_V_SYNC(OUT_V_SYNC),
		.OUT_V_BACK(OUT_V_BACK)
	) timing (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_start(gen_start),
		.o_running(gen_running),
		.o_hpos(gen_hpos),
		.o_vpos(gen_vpos),
		.o_h_active(gen_h_active),
		.o_v_active(gen_v_active),
		.o_sync(gen_sync)
	);

	////////////////////////////////////////////////////////////
	// Control

	upscaler_ctrl #(
		.LINE_BUFFER_COUNT(LINE_BUFFER_COUNT)
	) ctrl (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_locked(mon_locked),
		.i_width(o_src_width),
		.i_height(o_src_height),
		.i_src_line(mon_src_line),
		.i_frame_start(mon_frame_start),
		.o_wr_slot(wr_slot),
		.o_div_req(div_req),
		.o_div_op(div_op),
		.i_div_ack(div_ack),
		.i_div_rsp(div_rsp),
		.o_start(gen_start),
		.i_running(gen_running),
		.i_hpos(gen_hpos),
		.i_vpos(gen_vpos),
		.i_h_active(gen_h_active),
		.i_v_active(gen_v_active),
		.i_sync(gen_sync),
		.o_rd_slot(rd_slot),
		.o_rd_col(rd_col),
		.i_rd_rgb(rd_rgb),
		.o_rgb(o_rgb),
		.o_sync(o_sync),
		.o_out_valid(o_out_valid),
		.o_locked(o_locked)
	);

endmodule

`default_nettype wire

/* tests/tb_video_upscaler.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_video_upscaler;

	localparam int CLK_PERIOD = 8;
	localparam int LINE_BUFFER_COUNT = 8;
	localparam int LINE_MAX = 64;

	// Small output raster keeps frames short
	localparam int OUT_H_ACTIVE = 40;
	localparam int OUT_H_FRONT = 4;
	localparam int OUT_H_SYNC = 8;
	localparam int OUT_H_BACK = 4;
	localparam int OUT_V_ACTIVE = 30;
	localparam int OUT_V_FRONT = 2;
	localparam int OUT_V_SYNC = 2;
	localparam int OUT_V_BACK = 3;
	localparam int H_TOTAL = OUT_H_ACTIVE + OUT_H_FRONT + OUT_H_SYNC + OUT_H_BACK;
	localparam int V_TOTAL = OUT_V_ACTIVE + OUT_V_FRONT + OUT_V_SYNC + OUT_V_BACK;
	localparam int OUT_FRAME_CYCLES = H_TOTAL * V_TOTAL;

	// Source rasters, before and after the resolution change
	localparam int SRC_W = 20;
	localparam int SRC_H = 16;
	localparam int SRC2_W = 30;
	localparam int SRC2_H = 12;
	localparam int SRC_H_BLANK = 6;
	localparam int SRC_V_BLANK = 4;
	localparam int PIX_PERIOD = 3;
	localparam int MAX_COLS = 32;
	localparam int SRC_FRAME_MAX = PIX_PERIOD * (SRC2_W + SRC_H_BLANK) * (SRC_H + SRC_V_BLANK);

	// Fixed-point step: source size * 2^12 / output active size
	localparam int STEP_FRAC_BITS = 12;
	localparam int RGB_BITS = $bits(video_pkg::rgb_t);
	localparam int LFSR_SEED = 41731;
	localparam int FRAMES_PER_TEST = 2;
	localparam int PIXELS_PER_TEST = FRAMES_PER_TEST * OUT_H_ACTIVE * OUT_V_ACTIVE;

	// Two lock phases, each a few source frames plus a drain and two output frames
	localparam int WATCHDOG_CYCLES = 2 * (6 * SRC_FRAME_MAX + 7 * OUT_FRAME_CYCLES);

	localparam video_pkg::video_sync_t IDLE_SYNC = 4'b1111;
	localparam video_pkg::src_pixel_t IDLE_SRC = '{rgb: '0, sync: IDLE_SYNC};

	logic clk;
	logic rst;
	video_pkg::src_pixel_t src;
	logic pix_en;
	video_pkg::rgb_t out_rgb;
	video_pkg::video_sync_t out_sync;
	logic out_valid;
	logic locked;
	video_pkg::dim_t src_width;
	video_pkg::dim_t src_height;

	// Source image, rows repeat every LINE_BUFFER_COUNT lines
	video_pkg::rgb_t image [LINE_BUFFER_COUNT][MAX_COLS];

	bit run_source;
	int gen_w;
	int gen_h;
	int exp_w;
	int exp_h;
	int frames_at_size;
	int main_errs;
	int pixel_errs;
	int timing_errs;
	int pixel_checks;
	int timing_checks;
	int out_frames;
	int tests_passed;
	int tests_failed;
	string stage;

	video_upscaler_top #(
		.LINE_BUFFER_COUNT(LINE_BUFFER_COUNT),
		.LINE_MAX(LINE_MAX),
		.OUT_H_ACTIVE(OUT_H_ACTIVE),
		.OUT_H_FRONT(OUT_H_FRONT),
		.OUT_H_SYNC(OUT_H_SYNC),
		.OUT_H_BACK(OUT_H_BACK),
		.OUT_V_ACTIVE(OUT_V_ACTIVE),
		.OUT_V_FRONT(OUT_V_FRONT),
		.OUT_V_SYNC(OUT_V_SYNC),
		.OUT_V_BACK(OUT_V_BACK)
	) DUT (
		.i_clk(clk),
		.i_rst(rst),
		.i_src(src),
		.i_src_pix_en(pix_en),
		.o_rgb(out_rgb),
		.o_sync(out_sync),
		.o_out_valid(out_valid),
		.o_locked(locked),
		.o_src_width(src_width),
		.o_src_height(src_height)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Helpers

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic fill_image();
		logic [15:0] lfsr;
		logic [RGB_BITS-1:0] bits;
		lfsr = 16'(LFSR_SEED);
		for (int r = 0; r < LINE_BUFFER_COUNT; r++) begin
			for (int c = 0; c < MAX_COLS; c++) begin
				bits = '0;
				// One LFSR step per bit
				for (int b = 0; b < RGB_BITS; b++) begin
					lfsr = lfsr_next(lfsr);
					bits = {bits[RGB_BITS-2:0], lfsr[0]};
				end
				image[r][c] = bits;
			end
		end
	endtask

	// Nearest neighbour: whole part of coordinate times step
	function automatic video_pkg::rgb_t expected_pixel(input int x, input int y,
			input int w, input int h);
		longint h_step;
		longint v_step;
		int sx;
		int sy;
		h_step = (longint'(w) << STEP_FRAC_BITS) / OUT_H_ACTIVE;
		v_step = (longint'(h) << STEP_FRAC_BITS) / OUT_V_ACTIVE;
		sx = int'((x * h_step) >> STEP_FRAC_BITS);
		sy = int'((y * v_step) >> STEP_FRAC_BITS);
		return image[sy % LINE_BUFFER_COUNT][sx];
	endfunction

	// One strobed pixel, then idle cycles
	task automatic send_pixel(input video_pkg::src_pixel_t px);
		@(posedge clk);
		src <= px;
		pix_en <= 1'b1;
		repeat (PIX_PERIOD - 1) begin
			@(posedge clk);
			pix_en <= 1'b0;
		end
	endtask

	task automatic check_length(input string what, input int got, input int expected);
		timing_checks++;
		if (got != expected) begin
			timing_errs++;
			$display("error at %0t ns: %s expected %0d got %0d", $time, what, expected, got);
		end
	endtask

	task automatic report_test(input string name, input bit ok);
		if (ok) begin
			tests_passed++;
		end else begin
			tests_failed++;
		end
		$display("test %0d %s: %s", tests_passed + tests_failed, name, ok ? "pass" : "fail");
	endtask

	////////////////////////////////////////////////////////////
	// Source frame generator

	initial begin : source_gen
		int w;
		int h;
		video_pkg::src_pixel_t px;
		w = 0;
		h = 0;
		wait (run_source);
		forever begin
			// New size taken only at a frame boundary
			if (gen_w != w || gen_h != h) begin
				frames_at_size = 0;
				w = gen_w;
				h = gen_h;
			end
			for (int row = 0; row < h + SRC_V_BLANK; row++) begin
				for (int col = 0; col < w + SRC_H_BLANK; col++) begin
					px.sync.hblank = col >= w;
					px.sync.vblank = row >= h;
					px.sync.hsync = !(col >= w + 2 && col < w + 4);
					px.sync.vsync = !(row >= h + 1 && row < h + 3);
					if (col < w && row < h) begin
						px.rgb = image[row % LINE_BUFFER_COUNT][col];
					end else begin
						px.rgb = '0;
					end
					// First vblank pixel closes the frame
					if (row == h && col == 0) begin
						frames_at_size++;
					end
					send_pixel(px);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Output comparator, sampled mid-cycle

	initial begin : compare_output
		video_pkg::video_sync_t s;
		video_pkg::video_sync_t prev;
		video_pkg::rgb_t exp_rgb;
		int x;
		int y;
		int hs_len;
		int vs_len;
		int act_len;
		prev = IDLE_SYNC;
		x = 0;
		y = 0;
		hs_len = 0;
		vs_len = 0;
		act_len = 0;
		wait (run_source);
		forever begin
			@(negedge clk);
			s = out_sync;
			if (!s.hblank && !s.vblank) begin
				if (out_valid) begin
					exp_rgb = expected_pixel(x, y, exp_w, exp_h);
					pixel_checks++;
					if (out_rgb !== exp_rgb) begin
						pixel_errs++;
						$display("error at %0t ns: o_rgb at (%0d, %0d) expected %h got %h",
							$time, x, y, exp_rgb, out_rgb);
					end
				end
				x++;
			end else begin
				x = 0;
				if (out_rgb !== '0) begin
					pixel_errs++;
					$display("error at %0t ns: o_rgb in blanking expected 000 got %h",
						$time, out_rgb);
				end
			end
			// Pulse and run lengths, checked at their trailing edge
			if (!s.hsync) begin
				hs_len++;
			end else if (!prev.hsync) begin
				check_length("o_sync.hsync low cycles", hs_len, OUT_H_SYNC);
				hs_len = 0;
			end
			if (!s.vsync) begin
				vs_len++;
			end else if (!prev.vsync) begin
				check_length("o_sync.vsync low cycles", vs_len, OUT_V_SYNC * H_TOTAL);
				vs_len = 0;
			end
			if (!s.hblank) begin
				act_len++;
			end else if (!prev.hblank) begin
				check_length("o_sync.hblank low cycles", act_len, OUT_H_ACTIVE);
				act_len = 0;
			end
			// Line count doubles as output y
			if (s.hblank && !prev.hblank && !s.vblank) begin
				y++;
			end
			if (s.vblank && !prev.vblank) begin
				check_length("o_sync active lines", y, OUT_V_ACTIVE);
				y = 0;
				if (out_valid) begin
					out_frames++;
				end
			end
			prev = s;
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin : run_tests
		int errs_before;
		int pix_before;
		int pix_errs_before;
		int tim_before;
		int tim_errs_before;
		int frames_before;
		int idle_cycles;
		rst <= 1'b1;
		src <= IDLE_SRC;
		pix_en <= 1'b0;
		gen_w = SRC_W;
		gen_h = SRC_H;
		exp_w = SRC_W;
		exp_h = SRC_H;
		stage = "reset";
		fill_image();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		run_source = 1'b1;

		// Idle outputs until the first lock
		stage = "first lock";
		errs_before = main_errs;
		idle_cycles = 0;
		@(negedge clk);
		while (!locked) begin
			if (out_valid !== 1'b0) begin
				main_errs++;
				$display("error at %0t ns: o_out_valid expected 0 got %b", $time, out_valid);
			end
			if (out_sync !== IDLE_SYNC) begin
				main_errs++;
				$display("error at %0t ns: o_sync expected %b got %b", $time, IDLE_SYNC,
					out_sync);
			end
			idle_cycles++;
			@(negedge clk);
		end
		if (idle_cycles == 0) begin
			main_errs++;
			$display("o_locked was already high right after reset");
		end
		report_test("reset state", main_errs == errs_before);

		errs_before = main_errs;
		if (src_width !== video_pkg::dim_t'(SRC_W)) begin
			main_errs++;
			$display("error at %0t ns: o_src_width expected %0d got %0d", $time, SRC_W,
				src_width);
		end
		if (src_height !== video_pkg::dim_t'(SRC_H)) begin
			main_errs++;
			$display("error at %0t ns: o_src_height expected %0d got %0d", $time, SRC_H,
				src_height);
		end
		if (frames_at_size != 2) begin
			main_errs++;
			$display("lock rose after %0d source frames instead of 2", frames_at_size);
		end
		report_test("source geometry and lock", main_errs == errs_before);

		// Whole output frames at the first size
		stage = "first valid output";
		wait (out_valid);
		pix_before = pixel_checks;
		pix_errs_before = pixel_errs;
		tim_before = timing_checks;
		tim_errs_before = timing_errs;
		frames_before = out_frames;
		errs_before = main_errs;
		stage = "output frames at first size";
		wait (out_frames == frames_before + FRAMES_PER_TEST);
		report_test("output timing",
			timing_errs == tim_errs_before && timing_checks > tim_before);
		if (pixel_checks - pix_before != PIXELS_PER_TEST) begin
			main_errs++;
			$display("%0d active pixels were checked instead of %0d",
				pixel_checks - pix_before, PIXELS_PER_TEST);
		end
		report_test("pixel content", pixel_errs == pix_errs_before && main_errs == errs_before);

		// Resolution change, then relock
		errs_before = main_errs;
		pix_errs_before = pixel_errs;
		tim_errs_before = timing_errs;
		gen_w = SRC2_W;
		gen_h = SRC2_H;
		stage = "lock to drop";
		wait (!locked);
		exp_w = SRC2_W;
		exp_h = SRC2_H;
		stage = "relock";
		wait (locked);
		if (src_width !== video_pkg::dim_t'(SRC2_W)) begin
			main_errs++;
			$display("error at %0t ns: o_src_width expected %0d got %0d", $time, SRC2_W,
				src_width);
		end
		if (src_height !== video_pkg::dim_t'(SRC2_H)) begin
			main_errs++;
			$display("error at %0t ns: o_src_height expected %0d got %0d", $time, SRC2_H,
				src_height);
		end
		stage = "valid output at new size";
		wait (out_valid);
		pix_before = pixel_checks;
		frames_before = out_frames;
		stage = "output frames at new size";
		wait (out_frames == frames_before + FRAMES_PER_TEST);
		if (pixel_checks - pix_before != PIXELS_PER_TEST) begin
			main_errs++;
			$display("%0d active pixels were checked instead of %0d",
				pixel_checks - pix_before, PIXELS_PER_TEST);
		end
		report_test("resolution change", main_errs == errs_before &&
			pixel_errs == pix_errs_before && timing_errs == tim_errs_before);

		$display("tests %0d passed %0d failed, pixel checks %0d, timing checks %0d, errors %0d",
			tests_passed, tests_failed, pixel_checks, timing_checks,
			main_errs + pixel_errs + timing_errs);
		if (tests_failed == 0 && main_errs + pixel_errs + timing_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles while waiting for %s", WATCHDOG_CYCLES, stage);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* video_upscaler.f */
source/video_pkg.sv
source/scaler_pkg.sv
source/vga_timing_gen.sv
source/video_timing_monitor.sv
source/line_buffer_ring.sv
source/scale_step_divider.sv
source/upscaler_ctrl.sv
source/video_upscaler_top.sv
tests/tb_video_upscaler.sv
